// File: hw/acc_config.svh
`ifndef ACC_CONFIG_SVH
`define ACC_CONFIG_SVH

// Square array, rows and columns alike
`define ACC_PE_SIZE     4

`define ACC_DATA_WIDTH  8   // Activation, weight, quantized output
`define ACC_PSUM_WIDTH  24  // Partial and accumulated sums

// One above the top bit of the output byte
`define ACC_SLICE_IDX   20

`define ACC_TILE_NUM    3   // Weight tiles summed per output block

// Output rows per tile, also entries per column FIFO
`define ACC_FIFO_DEPTH  4

`endif

// File: hw/acc_pkg.sv
`include "acc_config.svh"

package acc_pkg;

    typedef logic signed [`ACC_DATA_WIDTH-1:0] data_t;  // Activation or weight
    typedef logic signed [`ACC_PSUM_WIDTH-1:0] psum_t;  // Partial or accumulated sum
    typedef logic        [`ACC_DATA_WIDTH-1:0] qout_t;  // Sliced output byte

    // Element r feeds array row r
    typedef struct packed {
        data_t [`ACC_PE_SIZE-1:0] act;
    } act_vec_t;

    // Bottom-row sums and their per-column write enables
    typedef struct packed {
        psum_t [`ACC_PE_SIZE-1:0] psum;
        logic  [`ACC_PE_SIZE-1:0] en;
    } psum_row_t;

    typedef struct packed {
        qout_t [`ACC_PE_SIZE-1:0] q;  // Column j in element j
    } ofmap_row_t;

    // Tile counter states
    typedef enum logic [1:0] {
        ACCUMULATE,
        FINAL_TILE,
        FLUSH
    } cnt_state_e;

endpackage

// File: hw/mac_pe.sv
module mac_pe (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           weight_load_i,  // Weights shift down one row
    input  acc_pkg::data_t weight_i,       // From the cell above
    input  acc_pkg::data_t act_i,          // From the cell to the left
    input  logic           act_valid_i,
    input  acc_pkg::psum_t psum_i,         // Sum coming down
    output acc_pkg::data_t weight_o,
    output acc_pkg::data_t act_o,          // To the right neighbour
    output logic           act_valid_o,
    output acc_pkg::psum_t psum_o          // To the cell below
);
    import acc_pkg::*;

    data_t weight_q;     // Stationary weight
    data_t act_q;
    logic  act_valid_q;
    psum_t psum_q;
    psum_t product;

    // Both operands sign extended to full sum width
    assign product = psum_t'(weight_q) * psum_t'(act_i);

    always_ff @(posedge clk) begin
        if (weight_load_i) begin
            weight_q <= weight_i;
        end
        act_q  <= act_i;             // Activation moves one column right
        psum_q <= psum_i + product;  // MAC
    end

    // Valid bit travels with the activation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_valid_q <= 1'b0;
        end else begin
            act_valid_q <= act_valid_i;
        end
    end

    assign weight_o    = weight_q;
    assign act_o       = act_q;
    assign act_valid_o = act_valid_q;
    assign psum_o      = psum_q;

endmodule

// File: hw/systolic_array.sv
`include "acc_config.svh"

module systolic_array (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                weight_load_i,  // Level, one row per cycle
    input  acc_pkg::data_t [`ACC_PE_SIZE-1:0]   weight_col_i,   // Enters the top row
    input  logic                                ifmap_valid_i,
    input  acc_pkg::act_vec_t                   ifmap_i,
    output acc_pkg::psum_row_t                  psum_row_o
);
    import acc_pkg::*;

    localparam int N = `ACC_PE_SIZE;

    // Activations and valids run left to right
    data_t act_w    [N][N+1];
    logic  vld_w    [N][N+1];
    // Weights and sums run top to bottom
    data_t weight_w [N+1][N];
    psum_t psum_w   [N+1][N];

    genvar r, c;

    // Row r sees its element r+1 cycles after presentation
    for (r = 0; r < N; r++) begin : g_skew
        data_t act_sk [r+1];
        logic  vld_sk [r+1];

        always_ff @(posedge clk) begin
            act_sk[0] <= ifmap_valid_i ? ifmap_i.act[r] : '0;  // Idle slots carry zeros
            for (int k = 1; k <= r; k++) begin
                act_sk[k] <= act_sk[k-1];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int k = 0; k <= r; k++) begin
                    vld_sk[k] <= 1'b0;
                end
            end else begin
                vld_sk[0] <= ifmap_valid_i;
                for (int k = 1; k <= r; k++) begin
                    vld_sk[k] <= vld_sk[k-1];
                end
            end
        end

        assign act_w[r][0] = act_sk[r];
        assign vld_w[r][0] = vld_sk[r];
    end

    // Top edge of the grid
    for (c = 0; c < N; c++) begin : g_top
        assign weight_w[0][c] = weight_col_i[c];
        assign psum_w[0][c]   = '0;  // No sum above row 0
    end

    for (r = 0; r < N; r++) begin : g_row
        for (c = 0; c < N; c++) begin : g_col
            mac_pe u_pe (
                .clk           (clk),
                .rst_n         (rst_n),
                .weight_load_i (weight_load_i),
                .weight_i      (weight_w[r][c]),
                .act_i         (act_w[r][c]),
                .act_valid_i   (vld_w[r][c]),
                .psum_i        (psum_w[r][c]),
                .weight_o      (weight_w[r+1][c]),
                .act_o         (act_w[r][c+1]),
                .act_valid_o   (vld_w[r][c+1]),
                .psum_o        (psum_w[r+1][c])
            );
        end
    end

    // Bottom cell's registered valid lines up with its sum
    always_comb begin
        for (int k = 0; k < N; k++) begin
            psum_row_o.psum[k] = psum_w[N][k];
            psum_row_o.en[k]   = vld_w[N-1][k+1];  // Vector at t lands at t+N+k+1
        end
    end

endmodule

// File: hw/psum_fifo.sv
`include "acc_config.svh"

module psum_fifo #(
    parameter int DATA_WIDTH = `ACC_PSUM_WIDTH,
    parameter int FIFO_DEPTH = `ACC_FIFO_DEPTH
) (
    input  logic           clk,
    input  logic           rst_n,    // Clears pointers and count only
    input  logic           wren_i,
    input  logic           rden_i,
    input  acc_pkg::psum_t wdata_i,
    output logic           full_o,
    output logic           empty_o,
    output acc_pkg::psum_t rdata_o   // Head entry, no read latency
);
    import acc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;    // Occupancy
    logic                  do_wr;
    logic                  do_rd;

    assign full_o  = (count == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign do_wr   = wren_i && (!full_o || rden_i);  // Full only with a read alongside
    assign do_rd   = rden_i && !empty_o;
    assign rdata_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Read plus write keeps occupancy
            endcase
        end
    end

endmodule

// File: hw/acc_counter.sv
`include "acc_config.svh"

module acc_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic psum_en_i,      // Column-0 write strobe
    output logic ofmap_valid_o,  // Column-0 output valid
    output logic flush_o         // One cycle after the last final write
);
    import acc_pkg::*;

    localparam int BLOCK_WR    = `ACC_TILE_NUM * `ACC_FIFO_DEPTH;        // Writes per block
    localparam int FINAL_START = (`ACC_TILE_NUM - 1) * `ACC_FIFO_DEPTH;  // First final write
    localparam int CNT_W       = $clog2(BLOCK_WR);

    cnt_state_e       state_q;
    cnt_state_e       state_d;
    logic [CNT_W-1:0] wr_cnt_q;  // Column-0 writes so far in this block
    logic [CNT_W-1:0] wr_cnt_d;

    always_comb begin
        state_d  = state_q;
        wr_cnt_d = wr_cnt_q;
        case (state_q)
            ACCUMULATE: begin
                if (psum_en_i) begin
                    wr_cnt_d = wr_cnt_q + 1'b1;
                    if (wr_cnt_q == CNT_W'(FINAL_START - 1)) begin
                        state_d = FINAL_TILE;  // Next tile is the last
                    end
                end
            end
            FINAL_TILE: begin
                if (psum_en_i) begin
                    wr_cnt_d = wr_cnt_q + 1'b1;
                    if (wr_cnt_q == CNT_W'(BLOCK_WR - 1)) begin
                        wr_cnt_d = '0;
                        state_d  = FLUSH;
                    end
                end
            end
            default: state_d = ACCUMULATE;  // FLUSH lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ACCUMULATE;
            wr_cnt_q <= '0;
        end else begin
            state_q  <= state_d;
            wr_cnt_q <= wr_cnt_d;
        end
    end

    assign ofmap_valid_o = (state_q == FINAL_TILE) && psum_en_i;
    assign flush_o       = (state_q == FLUSH);

endmodule

// File: hw/psum_accumulator.sv
`include "acc_config.svh"

module psum_accumulator (
    input  logic                clk,
    input  logic                rst_n,
    input  acc_pkg::psum_row_t  psum_row_i,   // Skewed sums and write enables
    output acc_pkg::ofmap_row_t ofmap_row_o,
    output logic                ofmap_valid_o // Column 0 timing, column j is j cycles later
);
    import acc_pkg::*;

    localparam int N = `ACC_PE_SIZE;

    psum_t        fifo_rdata [N];  // Head of each column FIFO
    psum_t        fifo_wdata [N];  // Feedback plus new sum
    logic [N-1:0] fifo_full;       // Tile already stored
    logic [N-1:0] fifo_rden;
    logic [N-1:0] fifo_rst_n;
    logic [N-1:0] flush_sr;        // Bit j clears column j
    logic         flush;

    acc_counter u_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_en_i     (psum_row_i.en[0]),
        .ofmap_valid_o (ofmap_valid_o),
        .flush_o       (flush)
    );

    // Flush walks right one column per cycle, same skew as the sums
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush_sr <= '0;
        end else begin
            flush_sr <= {flush_sr[N-2:0], flush};
        end
    end

    genvar j;
    for (j = 0; j < N; j++) begin : g_col
        psum_t feedback;

        // Zero while the first tile preloads
        assign feedback      = fifo_full[j] ? fifo_rdata[j] : '0;
        assign fifo_wdata[j] = feedback + psum_row_i.psum[j];
        assign fifo_rden[j]  = psum_row_i.en[j] & fifo_full[j];  // Pop what is added back
        assign fifo_rst_n[j] = rst_n & ~flush_sr[j];

        psum_fifo #(
            .DATA_WIDTH (`ACC_PSUM_WIDTH),
            .FIFO_DEPTH (`ACC_FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst_n   (fifo_rst_n[j]),
            .wren_i  (psum_row_i.en[j]),
            .rden_i  (fifo_rden[j]),
            .wdata_i (fifo_wdata[j]),
            .full_o  (fifo_full[j]),
            .empty_o (),
            .rdata_o (fifo_rdata[j])
        );
    end

    // Quantize by plain slicing of the write value
    always_comb begin
        for (int k = 0; k < N; k++) begin
            ofmap_row_o.q[k] = fifo_wdata[k][`ACC_SLICE_IDX-1 -: `ACC_DATA_WIDTH];
        end
    end

endmodule

// File: hw/acc_top.sv
`include "acc_config.svh"

module acc_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              weight_load_i,
    input  acc_pkg::data_t [`ACC_PE_SIZE-1:0] weight_col_i,
    input  logic                              ifmap_valid_i,
    input  acc_pkg::act_vec_t                 ifmap_i,
    output acc_pkg::ofmap_row_t               ofmap_row_o,
    output logic                              ofmap_valid_o
);
    import acc_pkg::*;

    psum_row_t psum_row;  // Array bottom row to accumulator

    systolic_array u_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .weight_load_i (weight_load_i),
        .weight_col_i  (weight_col_i),
        .ifmap_valid_i (ifmap_valid_i),
        .ifmap_i       (ifmap_i),
        .psum_row_o    (psum_row)
    );

    psum_accumulator u_acc (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_row_i    (psum_row),
        .ofmap_row_o   (ofmap_row_o),
        .ofmap_valid_o (ofmap_valid_o)
    );

endmodule

// File: tb/tb_acc_top.sv
`include "acc_config.svh"

module tb_acc_top;
    import acc_pkg::*;

    localparam int N     = `ACC_PE_SIZE;
    localparam int DEPTH = `ACC_FIFO_DEPTH;
    localparam int TILES = `ACC_TILE_NUM;
    localparam int NT    = 5;   // Rows in the test table
    localparam int MAXB  = 2;   // Most blocks in one test
    localparam int MAXR  = 32;  // Output rows over the whole run

    typedef enum int {W_ZERO, W_IDENT, W_MAX, W_RAND} wmode_e;
    typedef enum int {A_RAMP, A_NEG, A_RAND} amode_e;

    // Test table, one entry per test
    string  tname   [NT] = '{"zero_weights", "identity_ramp", "max_neg128", "random_one",
                             "random_two"};
    wmode_e twmode  [NT] = '{W_ZERO, W_IDENT, W_MAX, W_RAND, W_RAND};
    amode_e tamode  [NT] = '{A_RAND, A_RAMP, A_NEG, A_RAND, A_RAND};
    int     tblocks [NT] = '{1, 1, 1, 1, 2};

    logic            clk;
    logic            rst_n;
    logic            weight_load;
    data_t [N-1:0]   weight_col;
    logic            ifmap_valid;
    act_vec_t        ifmap;
    ofmap_row_t      ofmap_row;
    logic            ofmap_valid;

    data_t        w_tab [MAXB][TILES][N][N];      // Block, tile, row, column
    data_t        a_tab [MAXB][TILES][DEPTH][N];  // Block, tile, vector, row
    qout_t        exp_q [MAXR][N];                // Expected output bytes
    int           exp_vcyc [MAXR];                // Cycles where valid must be high
    int           vwr = 0;
    int           vrd = 0;
    int           cyc = 0;                        // Falling edges seen
    int           valid_cnt = 0;
    int           errors = 0;
    int           checks = 0;
    int           col_cnt [N] = '{default: 0};    // Rows checked per column
    logic [N-1:0] vhist = '0;                     // Bit j is valid j cycles ago
    int           seed = 32'hb435;

    acc_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .weight_load_i (weight_load),
        .weight_col_i  (weight_col),
        .ifmap_valid_i (ifmap_valid),
        .ifmap_i       (ifmap),
        .ofmap_row_o   (ofmap_row),
        .ofmap_valid_o (ofmap_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Cycle budget from block counts
    function automatic int timeout_cycles();
        int total;
        total = 0;
        for (int k = 0; k < NT; k++) total += tblocks[k] * TILES * (DEPTH + 2 * N) * 2;
        return total;
    endfunction

    initial begin : watchdog
        int wd_cnt;
        wd_cnt = 0;
        while (wd_cnt < timeout_cycles()) begin
            @(posedge clk);
            wd_cnt++;
        end
        $display("Timeout: outputs still missing after %0d clock cycles", wd_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_ofmap(input qout_t got, input qout_t exp, input int col, input int row);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: column %0d row %0d got %02h expected %02h",
                     $time, col, row, got, exp);
        end
    endtask

    task automatic check_valid_level(input logic got, input logic exp, input int at_cyc);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: ofmap_valid_o %b in cycle %0d, expected %b",
                     $time, got, at_cyc, exp);
        end
    endtask

    task automatic check_valid_count(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %0d valid cycles, expected %0d", $time, got, exp);
        end
    endtask

    // Falling edge, outputs settled since the rising edge; inputs are driven after return
    task automatic tick();
        logic exp_v;
        @(negedge clk);
        cyc++;
        exp_v = (vrd < vwr) && (exp_vcyc[vrd] == cyc);
        check_valid_level(ofmap_valid, exp_v, cyc);
        if (exp_v) vrd++;
        if (ofmap_valid) valid_cnt++;
        vhist = {vhist[N-2:0], ofmap_valid};
        for (int j = 0; j < N; j++) begin
            if (vhist[j]) begin  // Column j trails column 0 by j cycles
                check_ofmap(ofmap_row.q[j], exp_q[col_cnt[j]][j], j, col_cnt[j]);
                col_cnt[j]++;
            end
        end
    endtask

    // Stimulus per table entry plus reference rows
    task automatic make_test(input int tn, input int row_base);
        psum_t acc;
        for (int b = 0; b < tblocks[tn]; b++) begin
            for (int t = 0; t < TILES; t++) begin
                for (int r = 0; r < N; r++) begin
                    for (int c = 0; c < N; c++) begin
                        case (twmode[tn])
                            W_ZERO:  w_tab[b][t][r][c] = '0;
                            W_IDENT: w_tab[b][t][r][c] = data_t'((r == c) ? 1 : 0);
                            W_MAX:   w_tab[b][t][r][c] = data_t'(127);
                            default: w_tab[b][t][r][c] = data_t'($random(seed));
                        endcase
                    end
                end
                for (int i = 0; i < DEPTH; i++) begin
                    for (int r = 0; r < N; r++) begin
                        case (tamode[tn])
                            A_RAMP:  a_tab[b][t][i][r] = data_t'(16 * (i * N + r) + 3 * t - 100);
                            A_NEG:   a_tab[b][t][i][r] = data_t'(-128);
                            default: a_tab[b][t][i][r] = data_t'($random(seed));
                        endcase
                    end
                end
            end
            // Dot products summed over tiles, then bits 19 down to 12
            for (int i = 0; i < DEPTH; i++) begin
                for (int c = 0; c < N; c++) begin
                    acc = '0;
                    for (int t = 0; t < TILES; t++) begin
                        for (int r = 0; r < N; r++) begin
                            acc = acc + psum_t'(w_tab[b][t][r][c]) * psum_t'(a_tab[b][t][i][r]);
                        end
                    end
                    exp_q[row_base + b * DEPTH + i][c] = acc[`ACC_SLICE_IDX-1 -: `ACC_DATA_WIDTH];
                end
            end
        end
    endtask

    // Weight load, DEPTH vectors back to back, then drain
    task automatic run_tile(input int b, input int t);
        int last_t;
        last_t = 0;
        for (int k = 0; k < N; k++) begin
            tick();
            weight_load = 1'b1;
            for (int c = 0; c < N; c++) weight_col[c] = w_tab[b][t][N-1-k][c];  // Bottom row first
        end
        for (int i = 0; i < DEPTH; i++) begin
            tick();
            weight_load = 1'b0;
            ifmap_valid = 1'b1;
            for (int r = 0; r < N; r++) ifmap.act[r] = a_tab[b][t][i][r];
            last_t = cyc;
            if (t == TILES - 1) begin
                exp_vcyc[vwr] = cyc + N + 1;  // Column 0 write of a final-tile vector
                vwr++;
            end
        end
        tick();
        ifmap_valid = 1'b0;
        ifmap = '0;
        while (cyc < last_t + 2 * N + 1) tick();  // Last column written, weights free
    endtask

    initial begin
        int err0;
        int vbase;
        int row_base;
        rst_n = 1'b0;
        weight_load = 1'b0;
        weight_col = '0;
        ifmap_valid = 1'b0;
        ifmap = '0;
        row_base = 0;
        repeat (4) tick();
        rst_n = 1'b1;
        for (int tn = 0; tn < NT; tn++) begin
            err0 = errors;
            vbase = valid_cnt;
            make_test(tn, row_base);
            for (int b = 0; b < tblocks[tn]; b++) begin
                for (int t = 0; t < TILES; t++) run_tile(b, t);
            end
            row_base += tblocks[tn] * DEPTH;
            while (col_cnt[N-1] < row_base) tick();  // Wait for the last column
            check_valid_count(valid_cnt - vbase, tblocks[tn] * DEPTH);
            $display("%-14s blocks %0d: %s", tname[tn], tblocks[tn],
                     (errors == err0) ? "pass" : "fail");
        end
        $display("Tests %0d, checks %0d, errors %0d", NT, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/acc_pkg.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/psum_fifo.sv
hw/acc_counter.sv
hw/psum_accumulator.sv
hw/acc_top.sv
tb/tb_acc_top.sv

// File: run.sh
#!/bin/sh
# Build and run the accumulator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 -f compile.f --top-module tb_acc_top -o tb_acc_top
./obj_dir/tb_acc_top > sim.log 2>&1
cat sim.log
if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
